//--- Bender.yml
package:
  name: i2c_master

sources:
  - files:
      - hdl/i2c_pkg.sv
      - hdl/i2c_reg_file.sv
      - hdl/i2c_fifo.sv
      - hdl/i2c_bit_ctrl.sv
      - hdl/i2c_byte_ctrl.sv
      - hdl/i2c_master.sv
  - target: test
    files:
      - tb/i2c_slave_model.sv
      - tb/tb_i2c_master.sv

//--- hdl/i2c_bit_ctrl.sv
// I2C bit level controller

`timescale 1ns/100ps
`default_nettype none

module i2c_bit_ctrl (
    input  wire                            ps_clk,
    input  wire                            rstn_i,
    input  wire                            flush_i,
    input  wire  [i2c_pkg::PRESCALE_W-1:0] prescale_i,
    input  wire  i2c_pkg::bit_cmd_t        cmd_i,
    input  wire                            din_i,
    output logic                           bit_ack_o,
    output logic                           dout_o,
    output logic                           busy_o,
    input  wire                            scl_pad_i,
    output logic                           scl_pad_o,
    output logic                           scl_padoen_o,
    input  wire                            sda_pad_i,
    output logic                           sda_pad_o,
    output logic                           sda_padoen_o
);
    import i2c_pkg::*;

    logic                  active;
    logic [1:0]            phase;
    logic [PRESCALE_W-1:0] cnt;
    logic                  phase_end;

    assign phase_end = active & (cnt == prescale_i);
    assign bit_ack_o = phase_end & (phase == 2'd3);

    // open drain, the pads only ever pull low.
    assign scl_pad_o = 1'b0;
    assign sda_pad_o = 1'b0;

    // ************************************************************
    // four phases of prescale+1 cycles per command.
    always_ff @(posedge ps_clk) begin
        if (!rstn_i || flush_i) begin
            active <= 1'b0;
            phase  <= 2'd0;
            cnt    <= '0;
        end else if (!active) begin
            active <= (cmd_i != NONE);
            phase  <= 2'd0;
            cnt    <= '0;
        end else if (phase_end) begin
            active <= (phase != 2'd3);
            phase  <= phase + 2'd1;
            cnt    <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // pad levels per phase, held between commands.
    always_ff @(posedge ps_clk) begin
        if (!rstn_i || flush_i) begin
            scl_padoen_o <= 1'b1;
            sda_padoen_o <= 1'b1;
        end else if (active) begin
            case (cmd_i)
                START: begin
                    scl_padoen_o <= (phase != 2'd3);
                    sda_padoen_o <= (phase < 2'd2);
                end
                STOP: begin
                    scl_padoen_o <= (phase != 2'd0);
                    sda_padoen_o <= (phase == 2'd3);
                end
                WRITE: begin
                    scl_padoen_o <= phase[0] ^ phase[1];
                    sda_padoen_o <= din_i;
                end
                READ: begin
                    scl_padoen_o <= phase[0] ^ phase[1];
                    sda_padoen_o <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || flush_i) begin
            busy_o <= 1'b0;
        end else if (active && cmd_i == START) begin
            busy_o <= 1'b1;
        end else if (bit_ack_o && cmd_i == STOP) begin
            busy_o <= 1'b0;
        end
    end

    // sample at the end of the scl high phase.
    always_ff @(posedge ps_clk) begin
        if (phase_end && phase == 2'd2 && cmd_i == READ && scl_pad_i) begin
            dout_o <= sda_pad_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/i2c_byte_ctrl.sv
// I2C byte level controller

`timescale 1ns/100ps
`default_nettype none

module i2c_byte_ctrl (
    input  wire                                ps_clk,
    input  wire                                rstn_i,
    input  wire                                flush_i,
    input  wire  [i2c_pkg::PRESCALE_W-1:0]     prescale_i,
    input  wire                                start_i,
    input  wire                                stop_i,
    input  wire                                write_i,
    input  wire                                read_i,
    input  wire  [i2c_pkg::I2C_DATA_WIDTH-1:0] din_i,
    output logic                               cmd_ack_o,
    output logic                               ack_o,
    output logic [i2c_pkg::I2C_DATA_WIDTH-1:0] dout_o,
    output logic                               busy_o,
    input  wire                                scl_pad_i,
    output logic                               scl_pad_o,
    output logic                               scl_padoen_o,
    input  wire                                sda_pad_i,
    output logic                               sda_pad_o,
    output logic                               sda_padoen_o
);
    import i2c_pkg::*;

    localparam int CNT_W = $clog2(I2C_DATA_WIDTH);

    typedef enum logic [2:0] {ST_IDLE, ST_START, ST_DATA, ST_ACK, ST_STOP} state_t;

    state_t                    state;
    bit_cmd_t                  bit_cmd;
    logic                      bit_ack;
    logic                      bit_din;
    logic                      bit_dout;
    logic [CNT_W-1:0]          bit_cnt;
    logic [I2C_DATA_WIDTH-1:0] sr;

    // master NACKs the byte it reads.
    assign bit_din = (state == ST_ACK) ? 1'b1 : sr[I2C_DATA_WIDTH-1];
    assign dout_o  = sr;

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || flush_i) begin
            state     <= ST_IDLE;
            bit_cmd   <= NONE;
            bit_cnt   <= '0;
            cmd_ack_o <= 1'b0;
            ack_o     <= 1'b0;
        end else begin
            cmd_ack_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    bit_cnt <= CNT_W'(I2C_DATA_WIDTH - 1);
                    if (!cmd_ack_o && start_i) begin
                        state   <= ST_START;
                        bit_cmd <= START;
                    end else if (!cmd_ack_o && (write_i || read_i)) begin
                        state   <= ST_DATA;
                        bit_cmd <= write_i ? WRITE : READ;
                    end else if (!cmd_ack_o && stop_i) begin
                        state   <= ST_STOP;
                        bit_cmd <= STOP;
                    end
                end
                ST_START: begin
                    if (bit_ack) begin
                        state   <= ST_DATA;
                        bit_cmd <= write_i ? WRITE : READ;
                    end
                end
                ST_DATA: begin
                    if (bit_ack) begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == '0) begin
                            state   <= ST_ACK;
                            bit_cmd <= write_i ? READ : WRITE;
                        end
                    end
                end
                default: begin
                    // ack bit or stop finishes the command.
                    if (bit_ack) begin
                        state     <= ST_IDLE;
                        bit_cmd   <= NONE;
                        cmd_ack_o <= 1'b1;
                        if (state == ST_ACK && write_i) begin
                            ack_o <= bit_dout;
                        end
                    end
                end
            endcase
        end
    end

    // msb first, load from the tx head while idle.
    always_ff @(posedge ps_clk) begin
        if (state == ST_IDLE && !cmd_ack_o) begin
            sr <= din_i;
        end else if (state == ST_DATA && bit_ack) begin
            sr <= {sr[I2C_DATA_WIDTH-2:0], bit_dout};
        end
    end

    i2c_bit_ctrl i_bit_ctrl (
        .ps_clk      (ps_clk),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .prescale_i  (prescale_i),
        .cmd_i       (bit_cmd),
        .din_i       (bit_din),
        .bit_ack_o   (bit_ack),
        .dout_o      (bit_dout),
        .busy_o      (busy_o),
        .scl_pad_i   (scl_pad_i),
        .scl_pad_o   (scl_pad_o),
        .scl_padoen_o(scl_padoen_o),
        .sda_pad_i   (sda_pad_i),
        .sda_pad_o   (sda_pad_o),
        .sda_padoen_o(sda_padoen_o)
    );

endmodule

`default_nettype wire

//--- hdl/i2c_fifo.sv
// synchronous byte FIFO

`timescale 1ns/100ps
`default_nettype none

module i2c_fifo (
    input  wire                                ps_clk,
    input  wire                                rstn_i,
    input  wire                                flush_i,
    input  wire                                push_i,
    input  wire                                pop_i,
    input  wire  [i2c_pkg::I2C_DATA_WIDTH-1:0] wr_data_i,
    output logic [i2c_pkg::I2C_DATA_WIDTH-1:0] rd_data_o,
    output logic                               empty_o,
    output logic                               full_o
);
    import i2c_pkg::*;

    logic [I2C_DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]        wr_ptr;
    logic [FIFO_AW-1:0]        rd_ptr;
    logic [FIFO_AW:0]          count;
    logic                      do_push;
    logic                      do_pop;

    assign empty_o   = (count == '0);
    assign full_o    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_push   = push_i & ~full_o;
    assign do_pop    = pop_i & ~empty_o;
    // show-ahead head.
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{FIFO_AW{1'b0}}, do_push} - {{FIFO_AW{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge ps_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/i2c_master.sv
// I2C master top level

`timescale 1ns/100ps
`default_nettype none

module i2c_master (
    input  wire                    ps_clk,
    input  wire                    rstn_i,
    input  wire i2c_pkg::reg_req_t req_i,
    input  wire                    req_valid_i,
    output logic                   req_ready_o,
    output i2c_pkg::reg_rsp_t      rsp_o,
    output logic                   rsp_valid_o,
    input  wire                    scl_pad_i,
    output logic                   scl_pad_o,
    output logic                   scl_padoen_o,
    input  wire                    sda_pad_i,
    output logic                   sda_pad_o,
    output logic                   sda_padoen_o
);
    import i2c_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_STOP} seq_state_t;

    control_t                  control;
    status_t                   status;
    seq_state_t                state;
    logic [PRESCALE_W-1:0]     prescale;
    logic [REG_NUM-1:0]        wr_strobe;
    logic [REG_NUM-1:0]        rd_strobe;
    logic [I2C_DATA_WIDTH-1:0] reg_tx_data;
    logic [I2C_DATA_WIDTH-1:0] tx_head;
    logic [I2C_DATA_WIDTH-1:0] rx_head;
    logic [I2C_DATA_WIDTH-1:0] rx_byte;
    logic                      tx_empty;
    logic                      tx_full;
    logic                      rx_empty;
    logic                      rx_full;
    logic                      start;
    logic                      stop;
    logic                      write;
    logic                      read;
    logic                      cmd_ack;
    logic                      byte_ack;
    logic                      byte_busy;
    logic                      rx_ack_q;

    // ************************************************************
    // transfer sequencer.
    always_ff @(posedge ps_clk) begin
        if (!rstn_i || control.core_rst) begin
            state <= ST_IDLE;
            start <= 1'b0;
            stop  <= 1'b0;
            write <= 1'b0;
            read  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (control.core_en) begin
                        state <= ST_ADDR;
                        start <= 1'b1;
                        write <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    if (cmd_ack) begin
                        state <= ST_DATA;
                        start <= 1'b0;
                        write <= control.rw;
                        read  <= ~control.rw;
                    end
                end
                ST_DATA: begin
                    if (cmd_ack) begin
                        state <= ST_STOP;
                        stop  <= 1'b1;
                        write <= 1'b0;
                        read  <= 1'b0;
                    end
                end
                default: begin
                    if (cmd_ack) begin
                        state <= ST_IDLE;
                        stop  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (!rstn_i) begin
            rx_ack_q <= 1'b0;
        end else if (cmd_ack && write) begin
            rx_ack_q <= byte_ack;
        end
    end

    always_comb begin
        status.rx_fifo_empty = rx_empty;
        status.rx_fifo_full  = rx_full;
        status.tx_fifo_empty = tx_empty;
        status.tx_fifo_full  = tx_full;
        status.busy          = byte_busy | (state != ST_IDLE);
        status.rx_ack        = rx_ack_q;
    end

    i2c_reg_file i_reg_file (
        .ps_clk       (ps_clk),
        .rstn_i       (rstn_i),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_o        (rsp_o),
        .rsp_valid_o  (rsp_valid_o),
        .status_i     (status),
        .rx_data_i    (rx_head),
        .control_o    (control),
        .prescale_o   (prescale),
        .tx_data_o    (reg_tx_data),
        .wr_strobe_o  (wr_strobe),
        .rd_strobe_o  (rd_strobe),
        .clr_core_en_i(cmd_ack & stop)
    );

    i2c_fifo i_tx_fifo (
        .ps_clk   (ps_clk),
        .rstn_i   (rstn_i),
        .flush_i  (control.core_rst),
        .push_i   (wr_strobe[TX_DATA_REG_POS]),
        .pop_i    (cmd_ack & write),
        .wr_data_i(reg_tx_data),
        .rd_data_o(tx_head),
        .empty_o  (tx_empty),
        .full_o   (tx_full)
    );

    i2c_fifo i_rx_fifo (
        .ps_clk   (ps_clk),
        .rstn_i   (rstn_i),
        .flush_i  (control.core_rst),
        .push_i   (cmd_ack & read),
        .pop_i    (rd_strobe[RX_DATA_REG_POS]),
        .wr_data_i(rx_byte),
        .rd_data_o(rx_head),
        .empty_o  (rx_empty),
        .full_o   (rx_full)
    );

    i2c_byte_ctrl i_byte_ctrl (
        .ps_clk      (ps_clk),
        .rstn_i      (rstn_i),
        .flush_i     (control.core_rst),
        .prescale_i  (prescale),
        .start_i     (start),
        .stop_i      (stop),
        .write_i     (write),
        .read_i      (read),
        .din_i       (tx_head),
        .cmd_ack_o   (cmd_ack),
        .ack_o       (byte_ack),
        .dout_o      (rx_byte),
        .busy_o      (byte_busy),
        .scl_pad_i   (scl_pad_i),
        .scl_pad_o   (scl_pad_o),
        .scl_padoen_o(scl_padoen_o),
        .sda_pad_i   (sda_pad_i),
        .sda_pad_o   (sda_pad_o),
        .sda_padoen_o(sda_padoen_o)
    );

endmodule

`default_nettype wire

//--- hdl/i2c_pkg.sv
// I2C master shared types and constants

`default_nettype none

package i2c_pkg;

    // ************************************************************
    // sizing.
    localparam int I2C_DATA_WIDTH = 8;
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_AW        = 3;
    localparam int PRESCALE_W     = 16;

    // ************************************************************
    // register map, word addresses.
    localparam int REG_NUM         = 6;
    localparam int REG_AW          = 3;
    localparam int CONTROL_REG_POS = 0;
    localparam int CLK_REG_POS     = 1;
    localparam int STATUS_REG_POS  = 2;
    localparam int TX_DATA_REG_POS = 3;
    localparam int RX_DATA_REG_POS = 4;
    localparam int PARAM_REG_POS   = 5;

    typedef struct packed {
        logic [REG_AW-1:0] addr;
        logic              we;
        logic [31:0]       wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } reg_rsp_t;

    // control bits, core_en in bit 2 down to core_rst in bit 0.
    typedef struct packed {
        logic core_en;
        logic rw;
        logic core_rst;
    } control_t;

    typedef struct packed {
        logic rx_fifo_empty;
        logic rx_fifo_full;
        logic tx_fifo_empty;
        logic tx_fifo_full;
        logic busy;
        logic rx_ack;
    } status_t;

    // bit level commands.
    typedef enum logic [2:0] {NONE, START, STOP, WRITE, READ} bit_cmd_t;

endpackage

`default_nettype wire

//--- hdl/i2c_reg_file.sv
// I2C register bank

`timescale 1ns/100ps
`default_nettype none

module i2c_reg_file (
    input  wire                                ps_clk,
    input  wire                                rstn_i,
    input  wire  i2c_pkg::reg_req_t            req_i,
    input  wire                                req_valid_i,
    output logic                               req_ready_o,
    output i2c_pkg::reg_rsp_t                  rsp_o,
    output logic                               rsp_valid_o,
    input  wire  i2c_pkg::status_t             status_i,
    input  wire  [i2c_pkg::I2C_DATA_WIDTH-1:0] rx_data_i,
    output i2c_pkg::control_t                  control_o,
    output logic [i2c_pkg::PRESCALE_W-1:0]     prescale_o,
    output logic [i2c_pkg::I2C_DATA_WIDTH-1:0] tx_data_o,
    output logic [i2c_pkg::REG_NUM-1:0]        wr_strobe_o,
    output logic [i2c_pkg::REG_NUM-1:0]        rd_strobe_o,
    input  wire                                clr_core_en_i
);
    import i2c_pkg::*;

    logic        accept;
    logic [31:0] rd_data;

    // one request in flight, the response cycle blocks the next.
    assign req_ready_o = ~rsp_valid_o;
    assign accept      = req_valid_i & req_ready_o;
    assign tx_data_o   = req_i.wdata[I2C_DATA_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < REG_NUM; i++) begin
            wr_strobe_o[i] = accept & req_i.we & (req_i.addr == REG_AW'(i));
            rd_strobe_o[i] = accept & ~req_i.we & (req_i.addr == REG_AW'(i));
        end
    end

    always_comb begin
        rd_data = '0;
        case (req_i.addr)
            REG_AW'(CONTROL_REG_POS): rd_data[$bits(control_t)-1:0] = control_o;
            REG_AW'(CLK_REG_POS):     rd_data[PRESCALE_W-1:0]       = prescale_o;
            REG_AW'(STATUS_REG_POS):  rd_data[$bits(status_t)-1:0]  = status_i;
            REG_AW'(RX_DATA_REG_POS): rd_data[I2C_DATA_WIDTH-1:0]   = rx_data_i;
            REG_AW'(PARAM_REG_POS): begin
                rd_data[23:0] = {8'(REG_NUM), 8'(FIFO_DEPTH), 8'(I2C_DATA_WIDTH)};
            end
            default: ;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
            control_o   <= '0;
            prescale_o  <= '0;
        end else begin
            rsp_valid_o <= accept;
            if (wr_strobe_o[CONTROL_REG_POS]) begin
                control_o <= control_t'(req_i.wdata[$bits(control_t)-1:0]);
            end else if (clr_core_en_i) begin
                // transfer done.
                control_o.core_en <= 1'b0;
                control_o.rw      <= 1'b0;
            end
            if (wr_strobe_o[CLK_REG_POS]) begin
                prescale_o <= req_i.wdata[PRESCALE_W-1:0];
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (accept) begin
            rsp_o.rdata <= req_i.we ? '0 : rd_data;
        end
    end

endmodule

`default_nettype wire

//--- list.f
hdl/i2c_pkg.sv
hdl/i2c_reg_file.sv
hdl/i2c_fifo.sv
hdl/i2c_bit_ctrl.sv
hdl/i2c_byte_ctrl.sv
hdl/i2c_master.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

//--- tb/i2c_slave_model.sv
// behavioral I2C slave

`timescale 1ns/100ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] SLAVE_ADDR = 7'h2a
) (
    input  wire        scl_i,
    input  wire        sda_i,
    output logic       sda_oen_o,
    output logic [7:0] data_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_ADDR, S_ADDR_ACK, S_WDATA, S_WDATA_ACK, S_RDATA
    } slave_state_t;

    slave_state_t state     = S_IDLE;
    logic [7:0]   shreg     = 8'h00;
    logic [3:0]   bit_cnt   = 4'd0;
    logic         read_mode = 1'b0;
    logic         scl_q     = 1'b1;
    logic         sda_q     = 1'b1;

    initial begin
        sda_oen_o = 1'b1;
        data_o    = 8'h00;
    end

    // ************************************************************
    // bus events, sampled on scl rise and driven on scl fall.
    always @(scl_i or sda_i) begin
        if (scl_q === 1'b1 && scl_i === 1'b1 && sda_q === 1'b1 && sda_i === 1'b0) begin
            // start condition.
            state     = S_ADDR;
            bit_cnt   = 4'd0;
            sda_oen_o = 1'b1;
        end else if (scl_q === 1'b1 && scl_i === 1'b1 && sda_q === 1'b0 && sda_i === 1'b1) begin
            state     = S_IDLE;
            sda_oen_o = 1'b1;
        end else if (scl_q === 1'b0 && scl_i === 1'b1) begin
            if (state == S_ADDR || state == S_WDATA) begin
                shreg   = {shreg[6:0], sda_i};
                bit_cnt = bit_cnt + 4'd1;
            end
        end else if (scl_q === 1'b1 && scl_i === 1'b0) begin
            case (state)
                S_ADDR: begin
                    if (bit_cnt == 4'd8) begin
                        if (shreg[7:1] == SLAVE_ADDR) begin
                            read_mode = shreg[0];
                            sda_oen_o = 1'b0;
                            state     = S_ADDR_ACK;
                        end else begin
                            // not addressed, the released line is a NACK.
                            state = S_IDLE;
                        end
                    end
                end
                S_ADDR_ACK: begin
                    bit_cnt = 4'd0;
                    if (read_mode) begin
                        shreg     = data_o;
                        sda_oen_o = shreg[7];
                        shreg     = {shreg[6:0], 1'b0};
                        bit_cnt   = 4'd1;
                        state     = S_RDATA;
                    end else begin
                        sda_oen_o = 1'b1;
                        state     = S_WDATA;
                    end
                end
                S_WDATA: begin
                    if (bit_cnt == 4'd8) begin
                        data_o    = shreg;
                        sda_oen_o = 1'b0;
                        state     = S_WDATA_ACK;
                    end
                end
                S_RDATA: begin
                    if (bit_cnt == 4'd8) begin
                        // master acks or nacks, either way the byte is done.
                        sda_oen_o = 1'b1;
                        state     = S_IDLE;
                    end else begin
                        sda_oen_o = shreg[7];
                        shreg     = {shreg[6:0], 1'b0};
                        bit_cnt   = bit_cnt + 4'd1;
                    end
                end
                S_WDATA_ACK: begin
                    sda_oen_o = 1'b1;
                    state     = S_IDLE;
                end
                default: ;
            endcase
        end
        scl_q = scl_i;
        sda_q = sda_i;
    end

endmodule

`default_nettype wire

//--- tb/tb_i2c_master.sv
// I2C master testbench

`timescale 1ns/100ps
`default_nettype none

module tb_i2c_master;
    import i2c_pkg::*;

    localparam logic [6:0] SLAVE_ADDR     = 7'h2a;
    localparam int         MAX_PRESCALE   = 7;
    localparam int         TIMEOUT_CYCLES = 20 * 40 * 4 * (MAX_PRESCALE + 1) + 4000;

    logic       ps_clk;
    logic       rstn;
    reg_req_t   req;
    logic       req_valid;
    logic       req_ready;
    reg_rsp_t   rsp;
    logic       rsp_valid;
    logic       scl_pad_o;
    logic       scl_padoen;
    logic       sda_pad_o;
    logic       sda_padoen;
    logic       slave_sda_oen;
    logic [7:0] slave_data;
    tri1        scl;
    tri1        sda;

    int         n_errors;
    int         n_checks;
    int         cycle_cnt;
    int         exp_tx_cnt;
    logic [7:0] exp_store;
    logic       exp_ack;
    logic [7:0] exp_rx [$];

    i2c_master DUT (
        .ps_clk      (ps_clk),
        .rstn_i      (rstn),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .scl_pad_i   (scl),
        .scl_pad_o   (scl_pad_o),
        .scl_padoen_o(scl_padoen),
        .sda_pad_i   (sda),
        .sda_pad_o   (sda_pad_o),
        .sda_padoen_o(sda_padoen)
    );

    // open drain lines with pull-ups.
    assign scl = scl_padoen ? 1'bz : scl_pad_o;
    assign sda = sda_padoen ? 1'bz : sda_pad_o;
    assign sda = slave_sda_oen ? 1'bz : 1'b0;

    i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) i_slave (
        .scl_i    (scl),
        .sda_i    (sda),
        .sda_oen_o(slave_sda_oen),
        .data_o   (slave_data)
    );

    initial begin
        ps_clk = 1'b0;
        forever #50 ps_clk = ~ps_clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge ps_clk);
            cycle_cnt++;
        end
        $display("timeout: test did not finish within %0d cycles, %0d errors so far",
                 cycle_cnt, n_errors);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // ************************************************************
    // register bus accesses begin and end 1 ns after a rising edge.
    task automatic bus_access(input int addr, input logic we, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        req.addr  = REG_AW'(addr);
        req.we    = we;
        req.wdata = wdata;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge ps_clk);
            #1;
        end
        @(posedge ps_clk);
        #1;
        req_valid = 1'b0;
        // the response comes one cycle after acceptance and blocks the next request.
        check_value("rsp_valid_o", rsp_valid, 1'b1);
        check_value("req_ready_o", req_ready, 1'b0);
        rdata = rsp.rdata;
    endtask

    task automatic write_register(input int addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        bus_access(addr, 1'b1, wdata, rdata);
        check_value("rsp_o.rdata", rdata, 32'h0);
    endtask

    task automatic read_register(input int addr, output logic [31:0] rdata);
        bus_access(addr, 1'b0, 32'h0, rdata);
    endtask

    task automatic check_status();
        logic [31:0] rdata;
        status_t     exp;
        exp.rx_fifo_empty = (exp_rx.size() == 0);
        exp.rx_fifo_full  = (exp_rx.size() >= FIFO_DEPTH);
        exp.tx_fifo_empty = (exp_tx_cnt == 0);
        exp.tx_fifo_full  = (exp_tx_cnt >= FIFO_DEPTH);
        exp.busy          = 1'b0;
        exp.rx_ack        = exp_ack;
        read_register(STATUS_REG_POS, rdata);
        check_value("STATUS", rdata, {26'h0, exp});
    endtask

    task automatic wait_idle();
        logic [31:0] st_word;
        logic [31:0] ctl_word;
        status_t     st;
        control_t    ctl;
        do begin
            read_register(STATUS_REG_POS, st_word);
            read_register(CONTROL_REG_POS, ctl_word);
            st  = status_t'(st_word[$bits(status_t)-1:0]);
            ctl = control_t'(ctl_word[$bits(control_t)-1:0]);
        end while (st.busy || ctl.core_en);
    endtask

    task automatic run_transfer(input logic [6:0] addr7, input logic is_write,
                                input logic [7:0] data);
        control_t ctl;
        ctl.core_en  = 1'b1;
        ctl.rw       = is_write;
        ctl.core_rst = 1'b0;
        write_register(CLK_REG_POS, $urandom_range(MAX_PRESCALE, 1));
        // the r/w bit of the address byte is 1 for a read.
        write_register(TX_DATA_REG_POS, {24'h0, addr7, ~is_write});
        if (is_write) begin
            write_register(TX_DATA_REG_POS, {24'h0, data});
        end
        write_register(CONTROL_REG_POS, {29'h0, ctl});
        wait_idle();
        exp_tx_cnt = 0;
        if (addr7 != SLAVE_ADDR) begin
            exp_ack = 1'b1;
            if (!is_write) begin
                exp_rx.push_back(8'hff);
            end
        end else begin
            exp_ack = 1'b0;
            if (is_write) begin
                exp_store = data;
            end else begin
                exp_rx.push_back(exp_store);
            end
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [15:0] clk_val;
        logic [7:0]  data;
        logic [7:0]  exp_byte;
        logic [6:0]  bad_addr;
        n_errors   = 0;
        n_checks   = 0;
        exp_tx_cnt = 0;
        exp_store  = 8'h00;
        exp_ack    = 1'b0;
        void'($urandom(32'hd6a1));
        rstn      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        repeat (4) @(posedge ps_clk);
        #1;
        rstn = 1'b1;

        // reset values and parameters.
        check_value("req_ready_o", req_ready, 1'b1);
        check_value("rsp_valid_o", rsp_valid, 1'b0);
        check_value("scl_padoen_o", scl_padoen, 1'b1);
        check_value("sda_padoen_o", sda_padoen, 1'b1);
        check_value("scl_pad_o", scl_pad_o, 1'b0);
        check_value("sda_pad_o", sda_pad_o, 1'b0);
        read_register(PARAM_REG_POS, rdata);
        check_value("PARAM", rdata, {8'd0, 8'd6, 8'd8, 8'd8});
        check_status();
        clk_val = 16'($urandom());
        write_register(CLK_REG_POS, {16'h0, clk_val});
        read_register(CLK_REG_POS, rdata);
        check_value("CLK", rdata, {16'h0, clk_val});

        for (int i = 0; i < 8; i++) begin
            // each new byte differs from the stored one.
            data = exp_store ^ 8'($urandom_range(255, 1));
            run_transfer(SLAVE_ADDR, 1'b1, data);
            check_value("slave storage", slave_data, exp_store);
            check_status();
        end

        // write then read back through the rx FIFO.
        for (int i = 0; i < 4; i++) begin
            data = 8'($urandom());
            run_transfer(SLAVE_ADDR, 1'b1, data);
            run_transfer(SLAVE_ADDR, 1'b0, 8'h00);
            check_status();
            exp_byte = exp_rx.pop_front();
            read_register(RX_DATA_REG_POS, rdata);
            check_value("RX_DATA", rdata, {24'h0, exp_byte});
            check_status();
        end

        for (int i = 0; i < 3; i++) begin
            bad_addr = 7'($urandom());
            if (bad_addr == SLAVE_ADDR) begin
                bad_addr = bad_addr ^ 7'h01;
            end
            run_transfer(bad_addr, 1'b1, exp_store ^ 8'($urandom_range(255, 1)));
            check_value("slave storage", slave_data, exp_store);
            check_status();
        end

        // fill the tx FIFO while idle and flush it.
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            write_register(TX_DATA_REG_POS, {24'h0, 8'($urandom())});
            exp_tx_cnt++;
        end
        check_status();
        write_register(CONTROL_REG_POS, 32'h1);
        write_register(CONTROL_REG_POS, 32'h0);
        exp_tx_cnt = 0;
        exp_rx.delete();
        check_status();

        $display("tb_i2c_master: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
